// File: hw/dysta_pkg.sv
// Scheduler localparams, opcode and state enums, request field positions, table address function
package dysta_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////
  localparam int task_id_bits       = 4;
  localparam int num_tasks          = 16;
  localparam int score_bits         = 32;   // Scores, deadlines, times, latencies
  localparam int model_bits         = 5;
  localparam int pattern_bits       = 2;
  localparam int num_sparse_pattern = 4;
  localparam int max_layer          = 16;   // Layers per model
  localparam int layer_bits         = 4;
  localparam int lut_addr_bits      = 11;
  localparam int lut_depth          = 2048;

  // Field positions in request_data
  localparam int model_lsb   = 0;   // Bits 4..0
  localparam int pattern_lsb = 5;   // Bits 6..5
  localparam int task_id_lsb = 7;   // Bits 10..7

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    req_none          = 4'b0000,
    req_lut_base      = 4'b0001,  // Point latency writes at layer 0 of model/pattern
    req_lut_latency   = 4'b0010,  // Write latency, bump pointer
    req_task_model    = 4'b1000,
    req_task_deadline = 4'b1001,
    req_task_score    = 4'b1010
  } req_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_select,
    st_exe,
    st_scoring
  } sched_state_e;

  // Latency table row for one model, pattern and layer
  function automatic logic [lut_addr_bits-1:0] lut_addr(
    input logic [model_bits-1:0]   model,
    input logic [pattern_bits-1:0] pattern,
    input logic [layer_bits-1:0]   layer
  );
    lut_addr = lut_addr_bits'((model * num_sparse_pattern + pattern) * max_layer + layer);
  endfunction

endpackage

// File: hw/request_decoder.sv
// Host opcode decoder driving task table writes and latency table writes
`timescale 1ns/1ps

module request_decoder import dysta_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  req_op_e                  request_control,
  input  logic [31:0]              request_data,
  input  logic                     accept,
  output req_op_e                  tbl_wr_op,
  output logic [task_id_bits-1:0]  tbl_wr_id,
  output logic [31:0]              tbl_wr_data,
  output logic                     lut_wr_en,
  output logic [lut_addr_bits-1:0] lut_wr_addr,
  output logic [score_bits-1:0]    lut_wr_data
);

  logic [task_id_bits-1:0]  cur_id;    // Task being registered
  logic [lut_addr_bits-1:0] lut_ptr;   // Next latency entry
  logic [task_id_bits-1:0]  req_id;
  logic [model_bits-1:0]    req_model;
  logic [pattern_bits-1:0]  req_pattern;

  assign req_id      = request_data[task_id_lsb +: task_id_bits];
  assign req_model   = request_data[model_lsb +: model_bits];
  assign req_pattern = request_data[pattern_lsb +: pattern_bits];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tbl_wr_op <= req_none;
      lut_wr_en <= 1'b0;
      cur_id    <= '0;
      lut_ptr   <= '0;
    end else begin
      tbl_wr_op <= req_none;
      lut_wr_en <= 1'b0;
      if (accept) begin
        case (request_control)
          req_lut_base: lut_ptr <= lut_addr(req_model, req_pattern, '0);
          req_lut_latency: begin
            lut_wr_en <= 1'b1;
            lut_ptr   <= lut_ptr + 1'b1;  // Next layer
          end
          req_task_model: begin
            cur_id    <= req_id;
            tbl_wr_op <= req_task_model;
          end
          req_task_deadline, req_task_score: tbl_wr_op <= request_control;
          default: ;  // Unknown opcodes are dropped
        endcase
      end
    end
  end

  // Write payload, qualified by tbl_wr_op and lut_wr_en
  always_ff @(posedge clk) begin
    tbl_wr_id   <= (request_control == req_task_model) ? req_id : cur_id;
    tbl_wr_data <= request_data;
    lut_wr_addr <= lut_ptr;
    lut_wr_data <= request_data;
  end

endmodule

// File: hw/latency_lut.sv
// Simple dual-port latency RAM with registered read and read-valid flag
`timescale 1ns/1ps

module latency_lut import dysta_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic [lut_addr_bits-1:0] wr_addr,
  input  logic [score_bits-1:0]    wr_data,
  input  logic                     rd_en,
  input  logic [lut_addr_bits-1:0] rd_addr,
  output logic [score_bits-1:0]    rd_data,
  output logic                     rd_vld
);

  logic [score_bits-1:0] mem [lut_depth];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    if (rd_en) rd_data <= mem[rd_addr];  // One-cycle read
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) rd_vld <= 1'b0;
    else       rd_vld <= rd_en;
  end

endmodule

// File: hw/task_table.sv
// Per-slot task registers, valid bits, layer counters and system cycle counter
`timescale 1ns/1ps

module task_table import dysta_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  // Registration writes
  input  req_op_e                 tbl_wr_op,
  input  logic [task_id_bits-1:0] tbl_wr_id,
  input  logic [31:0]             tbl_wr_data,
  // Selector read port
  input  logic [task_id_bits-1:0] sel_rd_id,
  output logic                    sel_rd_valid,
  output logic [score_bits-1:0]   sel_rd_score,
  // Rescoring read port
  input  logic [task_id_bits-1:0] upd_rd_id,
  output logic                    upd_rd_valid,
  output logic [model_bits-1:0]   upd_rd_model,
  output logic [pattern_bits-1:0] upd_rd_pattern,
  output logic [layer_bits-1:0]   upd_rd_layer,
  output logic [score_bits-1:0]   upd_rd_deadline,
  output logic [score_bits-1:0]   upd_rd_arrival,
  // Score writeback
  input  logic                    score_wr_en,
  input  logic [task_id_bits-1:0] score_wr_id,
  input  logic [score_bits-1:0]   score_wr_data,
  // NPU progress
  input  logic                    compute_done_npu,
  input  logic                    last_layer_done_npu,
  input  logic [task_id_bits-1:0] active_id,
  output logic [31:0]             sys_clk,
  output logic                    any_valid
);

  logic [num_tasks-1:0]    valid;
  logic [model_bits-1:0]   model_q    [num_tasks];
  logic [pattern_bits-1:0] pattern_q  [num_tasks];
  logic [layer_bits-1:0]   layer_q    [num_tasks];
  logic [score_bits-1:0]   deadline_q [num_tasks];
  logic [score_bits-1:0]   arrival_q  [num_tasks];
  logic [score_bits-1:0]   score_q    [num_tasks];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid   <= '0;
      sys_clk <= '0;
    end else begin
      sys_clk <= sys_clk + 1'b1;  // Free running
      if (tbl_wr_op == req_task_score) valid[tbl_wr_id] <= 1'b1;
      if (compute_done_npu && last_layer_done_npu) begin
        valid[active_id] <= 1'b0;  // Retire
      end
    end
  end

  always_ff @(posedge clk) begin
    case (tbl_wr_op)
      req_task_model: begin
        model_q[tbl_wr_id]   <= tbl_wr_data[model_lsb +: model_bits];
        pattern_q[tbl_wr_id] <= tbl_wr_data[pattern_lsb +: pattern_bits];
      end
      req_task_deadline: begin
        deadline_q[tbl_wr_id] <= tbl_wr_data;
        arrival_q[tbl_wr_id]  <= sys_clk;  // Arrival stamp
      end
      req_task_score: begin
        score_q[tbl_wr_id] <= tbl_wr_data;
        layer_q[tbl_wr_id] <= '0;
      end
      default: ;
    endcase
    if (score_wr_en) score_q[score_wr_id] <= score_wr_data;
    if (compute_done_npu && !last_layer_done_npu) begin
      layer_q[active_id] <= layer_q[active_id] + 1'b1;
    end
  end

  assign sel_rd_valid    = valid[sel_rd_id];
  assign sel_rd_score    = score_q[sel_rd_id];
  assign upd_rd_valid    = valid[upd_rd_id];
  assign upd_rd_model    = model_q[upd_rd_id];
  assign upd_rd_pattern  = pattern_q[upd_rd_id];
  assign upd_rd_layer    = layer_q[upd_rd_id];
  assign upd_rd_deadline = deadline_q[upd_rd_id];
  assign upd_rd_arrival  = arrival_q[upd_rd_id];
  assign any_valid       = |valid;

endmodule

// File: hw/task_selector.sv
// Sequential slot scan for the valid task with the lowest score
`timescale 1ns/1ps

module task_selector import dysta_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    select_start,
  output logic [task_id_bits-1:0] sel_rd_id,
  input  logic                    sel_rd_valid,
  input  logic [score_bits-1:0]   sel_rd_score,
  output logic                    select_done,
  output logic [task_id_bits-1:0] best_id,
  output logic                    best_found
);

  logic                    scanning;
  logic [task_id_bits-1:0] idx;
  logic [score_bits-1:0]   best_score;
  logic                    better;

  assign sel_rd_id = idx;
  // Strict compare, so the lower slot keeps a tie
  assign better = sel_rd_valid && (!best_found || sel_rd_score < best_score);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scanning    <= 1'b0;
      idx         <= '0;
      select_done <= 1'b0;
      best_id     <= '0;
      best_found  <= 1'b0;
    end else begin
      select_done <= 1'b0;
      if (select_start) begin
        scanning   <= 1'b1;
        idx        <= '0;
        best_found <= 1'b0;
      end else if (scanning) begin
        if (better) begin
          best_found <= 1'b1;
          best_id    <= idx;
        end
        idx <= idx + 1'b1;
        if (idx == task_id_bits'(num_tasks - 1)) begin
          scanning    <= 1'b0;
          select_done <= 1'b1;  // num_tasks + 1 after start
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scanning && better) best_score <= sel_rd_score;
  end

endmodule

// File: hw/npu_dispatch.sv
// Scheduling FSM with NPU start, task select and ready output
`timescale 1ns/1ps

module npu_dispatch import dysta_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  req_op_e                 request_control,
  input  logic                    any_valid,
  input  logic                    select_done,
  input  logic [task_id_bits-1:0] best_id,
  input  logic                    best_found,
  input  logic                    compute_done_npu,
  input  logic                    rescore_done,
  output logic                    select_start,
  output logic                    rescore_start,
  output logic [task_id_bits-1:0] sel_task,
  output logic                    start_comp_npu,
  output logic                    scheduler_rdy,
  output logic                    accept
);

  sched_state_e            state;
  sched_state_e            state_next;
  logic [task_id_bits-1:0] active_id;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // Host traffic holds off selection
        if (any_valid && request_control == req_none) state_next = st_select;
      end
      st_select: if (select_done) state_next = best_found ? st_exe : st_idle;
      st_exe: if (compute_done_npu) state_next = st_scoring;
      st_scoring: if (rescore_done) state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= st_idle;
      active_id     <= '0;
      select_start  <= 1'b0;
      rescore_start <= 1'b0;
      scheduler_rdy <= 1'b0;
    end else begin
      state         <= state_next;
      select_start  <= (state == st_idle) && (state_next == st_select);
      rescore_start <= (state == st_exe) && (state_next == st_scoring);
      scheduler_rdy <= (state_next != st_scoring);  // Low only while rescoring
      if (state == st_select && select_done && best_found) active_id <= best_id;
    end
  end

  assign sel_task       = active_id;
  assign start_comp_npu = (state == st_exe);
  assign accept         = scheduler_rdy;

endmodule

// File: hw/score_engine.sv
// Three-stage rescoring pipeline over all valid task slots
`timescale 1ns/1ps

module score_engine import dysta_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rescore_start,
  output logic [task_id_bits-1:0]  upd_rd_id,
  input  logic                     upd_rd_valid,
  input  logic [model_bits-1:0]    upd_rd_model,
  input  logic [pattern_bits-1:0]  upd_rd_pattern,
  input  logic [layer_bits-1:0]    upd_rd_layer,
  input  logic [score_bits-1:0]    upd_rd_deadline,
  input  logic [score_bits-1:0]    upd_rd_arrival,
  input  logic [31:0]              sys_clk,
  output logic                     lut_rd_en,
  output logic [lut_addr_bits-1:0] lut_rd_addr,
  input  logic [score_bits-1:0]    lut_rd_data,
  input  logic                     lut_rd_vld,
  output logic                     score_wr_en,
  output logic [task_id_bits-1:0]  score_wr_id,
  output logic [score_bits-1:0]    score_wr_data,
  output logic                     rescore_done
);

  logic                    scanning;
  logic                    draining;
  logic [task_id_bits-1:0] idx;
  logic [task_id_bits-1:0] s1_id, s2_id;
  logic [score_bits-1:0]   s1_deadline, s1_arrival;
  logic [score_bits-1:0]   s2_deadline, s2_arrival;
  logic [score_bits-1:0]   elapsed;
  logic [score_bits:0]     used;  // Elapsed plus remaining latency

  assign upd_rd_id = idx;

  //////////////////////////////////////////////////////////////////////
  // Stage 1 address generation, one slot per cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scanning     <= 1'b0;
      draining     <= 1'b0;
      idx          <= '0;
      lut_rd_en    <= 1'b0;
      rescore_done <= 1'b0;
    end else begin
      lut_rd_en    <= 1'b0;
      rescore_done <= 1'b0;
      if (rescore_start) begin
        scanning <= 1'b1;
        idx      <= '0;
      end else if (scanning) begin
        lut_rd_en <= upd_rd_valid;  // Invalid slots issue nothing
        idx       <= idx + 1'b1;
        if (idx == task_id_bits'(num_tasks - 1)) begin
          scanning <= 1'b0;
          draining <= 1'b1;
        end
      end else if (draining && !lut_rd_en && !lut_rd_vld) begin
        draining     <= 1'b0;  // Last write has landed
        rescore_done <= 1'b1;
      end
    end
  end

  // Stages 1 and 2 payload
  always_ff @(posedge clk) begin
    lut_rd_addr <= lut_addr(upd_rd_model, upd_rd_pattern, upd_rd_layer);
    s1_id       <= idx;
    s1_deadline <= upd_rd_deadline;
    s1_arrival  <= upd_rd_arrival;
    s2_id       <= s1_id;
    s2_deadline <= s1_deadline;
    s2_arrival  <= s1_arrival;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 3 slack, clamped at zero
  //////////////////////////////////////////////////////////////////////
  assign elapsed = sys_clk - s2_arrival;
  assign used    = {1'b0, elapsed} + {1'b0, lut_rd_data};

  assign score_wr_en   = lut_rd_vld;
  assign score_wr_id   = s2_id;
  assign score_wr_data = (used >= {1'b0, s2_deadline}) ? '0
                                                       : s2_deadline - used[score_bits-1:0];

endmodule

// File: hw/dysta_scheduler.sv
// Top level of the deadline-slack NPU task scheduler
`timescale 1ns/1ps

module dysta_scheduler import dysta_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  req_op_e                 request_control,
  input  logic [31:0]             request_data,
  input  logic                    compute_done_npu,
  input  logic                    last_layer_done_npu,
  output logic [task_id_bits-1:0] sel_task,
  output logic                    start_comp_npu,
  output logic                    scheduler_rdy
);

  // Decoder to tables
  req_op_e                  tbl_wr_op;
  logic [task_id_bits-1:0]  tbl_wr_id;
  logic [31:0]              tbl_wr_data;
  logic                     lut_wr_en;
  logic [lut_addr_bits-1:0] lut_wr_addr;
  logic [score_bits-1:0]    lut_wr_data;
  logic                     accept;

  // Rescoring reads of the latency table
  logic                     lut_rd_en;
  logic [lut_addr_bits-1:0] lut_rd_addr;
  logic [score_bits-1:0]    lut_rd_data;
  logic                     lut_rd_vld;

  // Table read ports and writeback
  logic [task_id_bits-1:0]  sel_rd_id;
  logic                     sel_rd_valid;
  logic [score_bits-1:0]    sel_rd_score;
  logic [task_id_bits-1:0]  upd_rd_id;
  logic                     upd_rd_valid;
  logic [model_bits-1:0]    upd_rd_model;
  logic [pattern_bits-1:0]  upd_rd_pattern;
  logic [layer_bits-1:0]    upd_rd_layer;
  logic [score_bits-1:0]    upd_rd_deadline;
  logic [score_bits-1:0]    upd_rd_arrival;
  logic                     score_wr_en;
  logic [task_id_bits-1:0]  score_wr_id;
  logic [score_bits-1:0]    score_wr_data;
  logic [31:0]              sys_clk;
  logic                     any_valid;

  // Dispatch handshakes
  logic                     select_start;
  logic                     select_done;
  logic [task_id_bits-1:0]  best_id;
  logic                     best_found;
  logic                     rescore_start;
  logic                     rescore_done;

  request_decoder request_decoder_inst (.*);

  latency_lut latency_lut_inst (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (lut_wr_en),
    .wr_addr (lut_wr_addr),
    .wr_data (lut_wr_data),
    .rd_en   (lut_rd_en),
    .rd_addr (lut_rd_addr),
    .rd_data (lut_rd_data),
    .rd_vld  (lut_rd_vld)
  );

  task_table task_table_inst (
    .*,
    .active_id (sel_task)  // Task currently on the NPU
  );

  task_selector task_selector_inst (.*);

  npu_dispatch npu_dispatch_inst (.*);

  score_engine score_engine_inst (.*);

endmodule

// File: testbench/tb_tasks.svh
// Request helpers, NPU completion helper and directed test tasks for the scheduler testbench

//////////////////////////////////////////////////////////////////////
// Host and NPU helpers
//////////////////////////////////////////////////////////////////////
task automatic send_request(input req_op_e op, input logic [31:0] data);
  @(posedge clk);
  request_control <= op;
  request_data    <= data;
endtask

task automatic wait_ready();
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (!scheduler_rdy) begin
    cycles++;
    if (cycles > ready_limit) begin
      $display("Scheduler did not become ready within %0d cycles", ready_limit);
      end_with_failure();
    end
    @(negedge clk);
  end
endtask

task automatic wait_start();
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (!start_comp_npu) begin
    cycles++;
    if (cycles > start_limit) begin
      $display("NPU was not started within %0d cycles", start_limit);
      end_with_failure();
    end
    @(negedge clk);
  end
endtask

// Fills all layers of one model and pattern
// Remaining latency falls by step per layer
task automatic load_latency(input int model, input int pattern,
                            input logic [31:0] first, input logic [31:0] step);
  logic [31:0] lat;
  send_request(req_lut_base, (pattern << pattern_lsb) | (model << model_lsb));
  for (int l = 0; l < max_layer; l++) begin
    lat = first - step * l;
    ref_lut[lut_index(model, pattern, l)] = lat;
    send_request(req_lut_latency, lat);
  end
  send_request(req_none, '0);
endtask

// Score opcode stays on the bus until the caller's next request
task automatic add_task(input int id, input int model, input int pattern,
                        input logic [31:0] deadline, input logic [31:0] score);
  wait_ready();
  send_request(req_task_model,
               (id << task_id_lsb) | (pattern << pattern_lsb) | (model << model_lsb));
  send_request(req_task_deadline, deadline);
  send_request(req_task_score, score);
  ref_valid[id]    = 1'b1;
  ref_score[id]    = score;
  ref_deadline[id] = deadline;
  ref_model[id]    = model;
  ref_pattern[id]  = pattern;
  ref_layer[id]    = 0;
endtask

task automatic check_dispatch();
  int expected;
  expected = expected_next();
  wait_start();
  assert (int'(sel_task) == expected)
    else report_mismatch($sformatf("dispatched task %0d, expected task %0d",
                                   sel_task, expected));
endtask

// One-cycle done pulse for the task on the NPU and wait out the rescoring
task automatic complete_task(input logic last);
  int id;
  id = int'(sel_task);
  @(posedge clk);
  compute_done_npu    <= 1'b1;
  last_layer_done_npu <= last;
  @(posedge clk);
  compute_done_npu    <= 1'b0;
  last_layer_done_npu <= 1'b0;
  @(negedge clk);
  assert (!scheduler_rdy && !start_comp_npu)
    else report_mismatch("ready or NPU start still high while rescoring");
  if (last) ref_valid[id] = 1'b0;
  else      ref_layer[id] = ref_layer[id] + 1;
  rescore_reference();
  wait_ready();
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////
task automatic reset_outputs();
  repeat (reset_cycles) begin
    @(negedge clk);
    assert (!start_comp_npu && !scheduler_rdy)
      else report_mismatch("NPU start or ready high during reset");
  end
  @(posedge clk);
  reset <= 1'b0;
  for (int n = 0; n < 3 && !scheduler_rdy; n++) @(negedge clk);
  assert (scheduler_rdy && !start_comp_npu)
    else report_mismatch("not ready within 3 cycles of reset release");
endtask

task automatic single_task_dispatch();
  add_task(5, 0, 0, 200000, 1000);
  send_request(req_none, '0);
  check_dispatch();
  repeat (20) begin
    @(negedge clk);
    assert (start_comp_npu && sel_task == task_id_bits'(5))
      else report_mismatch("NPU start or task id changed before compute done");
  end
  complete_task(1'b1);
endtask

task automatic lowest_score_first();
  add_task(2, 1, 0, 600000, 700);
  add_task(9, 2, 1, 400000, 300);
  add_task(4, 3, 2, 800000, 500);
  send_request(req_none, '0);
  check_dispatch();  // Task 9 holds the lowest initial score
endtask

task automatic rescore_reorders();
  load_latency(1, 0, 500000, 20000);  // Long tail for task 2
  load_latency(2, 1, 20000, 1000);    // Short tail for task 9
  load_latency(3, 2, 100000, 5000);   // Task 4
  complete_task(1'b0);
  check_dispatch();
endtask

task automatic retire_all_tasks();
  complete_task(1'b1);  // Task already on the NPU
  while (expected_next() >= 0) begin
    check_dispatch();
    complete_task(1'b1);
  end
  repeat (200) begin
    @(negedge clk);
    assert (!start_comp_npu) else report_mismatch("NPU started with no task left");
  end
endtask

task automatic requests_hold_selection();
  add_task(11, 0, 3, 1000000, 2000);
  repeat (50) begin
    send_request(req_op_e'(4'b0011), $random(seed));  // Opcode with no effect
    @(negedge clk);
    assert (!start_comp_npu)
      else report_mismatch("NPU started while host requests were pending");
  end
  send_request(req_none, '0);
  check_dispatch();
  complete_task(1'b1);
endtask

// File: testbench/tb_dysta_scheduler.sv
// Testbench top with clock, reset, DUT instance, reference model, watchdog and test sequence
`timescale 1ns/1ps

module tb_dysta_scheduler import dysta_pkg::*; ();

  localparam int clk_period      = 100;
  localparam int reset_cycles    = 16;
  localparam int ready_limit     = 100;    // Rescoring of 16 slots plus drain
  localparam int start_limit     = 200;    // Idle, full slot scan, then execute
  localparam int watchdog_cycles = 20000;  // Far above the length of all tests together

  logic                    clk;
  logic                    reset;
  req_op_e                 request_control;
  logic [31:0]             request_data;
  logic                    compute_done_npu;
  logic                    last_layer_done_npu;
  logic [task_id_bits-1:0] sel_task;
  logic                    start_comp_npu;
  logic                    scheduler_rdy;

  integer seed;

  // Expected view of the task slots and the latency table
  logic                  ref_valid [];
  logic [score_bits-1:0] ref_score [];
  logic [score_bits-1:0] ref_deadline [];
  int                    ref_model [];
  int                    ref_pattern [];
  int                    ref_layer [];
  logic [score_bits-1:0] ref_lut [];

  dysta_scheduler dysta_scheduler_inst (
    .clk                 (clk),
    .reset               (reset),
    .request_control     (request_control),
    .request_data        (request_data),
    .compute_done_npu    (compute_done_npu),
    .last_layer_done_npu (last_layer_done_npu),
    .sel_task            (sel_task),
    .start_comp_npu      (start_comp_npu),
    .scheduler_rdy       (scheduler_rdy)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////
  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    end_with_failure();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic void clear_reference();
    ref_valid    = new[num_tasks];
    ref_score    = new[num_tasks];
    ref_deadline = new[num_tasks];
    ref_model    = new[num_tasks];
    ref_pattern  = new[num_tasks];
    ref_layer    = new[num_tasks];
    ref_lut      = new[lut_depth];
    for (int i = 0; i < num_tasks; i++) begin
      ref_valid[i] = 1'b0;
      ref_layer[i] = 0;
    end
    for (int a = 0; a < lut_depth; a++) ref_lut[a] = '0;
  endfunction

  // Rows by model, then pattern, then layer
  function automatic int lut_index(input int model, input int pattern, input int layer);
    return (model * num_sparse_pattern + pattern) * max_layer + layer;
  endfunction

  // Slack as deadline minus remaining latency
  // Elapsed time stays far below the deadline gaps
  function automatic void rescore_reference();
    logic [score_bits-1:0] lat;
    for (int i = 0; i < num_tasks; i++) begin
      if (ref_valid[i]) begin
        lat = ref_lut[lut_index(ref_model[i], ref_pattern[i], ref_layer[i])];
        ref_score[i] = (lat >= ref_deadline[i]) ? '0 : ref_deadline[i] - lat;
      end
    end
  endfunction

  function automatic int expected_next();
    int best;
    best = -1;
    for (int i = 0; i < num_tasks; i++) begin
      // Strict compare keeps the lower slot on ties
      if (ref_valid[i] && (best < 0 || ref_score[i] < ref_score[best])) best = i;
    end
    return best;
  endfunction

  `include "tb_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Clock, watchdog and test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the scheduler stopped responding",
             watchdog_cycles);
    end_with_failure();
  end

  initial begin
    seed                = 32'hc74b_82e9;
    reset               = 1'b1;
    request_control     = req_none;
    request_data        = '0;
    compute_done_npu    = 1'b0;
    last_layer_done_npu = 1'b0;
    clear_reference();

    reset_outputs();
    single_task_dispatch();
    lowest_score_first();
    rescore_reorders();
    retire_all_tasks();
    requests_hold_selection();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+testbench
hw/dysta_pkg.sv
hw/request_decoder.sv
hw/latency_lut.sv
hw/task_table.sv
hw/task_selector.sv
hw/npu_dispatch.sv
hw/score_engine.sv
hw/dysta_scheduler.sv
testbench/tb_dysta_scheduler.sv

// File: Makefile
# Verilator build and run for the DNN task scheduler
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_dysta_scheduler
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

SOURCES   = $(filter-out +incdir%,$(shell cat $(FILELIST))) testbench/tb_tasks.svh
BINARY    = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
